/* common/procPkg.sv */
/*
  shared definitions for the 16-bit pipelined core
  widths, register count and PC step
  opcodes and ALU function codes
  instruction word union with R, I and B views
*/
package procPkg;

  localparam int dataWidth   = 16;
  localparam int regCount    = 8;
  localparam int regIdxWidth = 3;

  // byte step per instruction
  localparam logic [dataWidth-1:0] pcStep = 16'd2;

  // opcodes, upper five bits of the word
  localparam logic [4:0] opHalt = 5'b00000;
  localparam logic [4:0] opNop  = 5'b00001;
  localparam logic [4:0] opAddi = 5'b01000;
  localparam logic [4:0] opXori = 5'b01010;
  localparam logic [4:0] opBeqz = 5'b01100;
  localparam logic [4:0] opBnez = 5'b01101;
  localparam logic [4:0] opLbi  = 5'b11000;
  localparam logic [4:0] opAlu  = 5'b11011;

  // ALU functions, also the func field of opAlu
  localparam logic [1:0] aluAdd  = 2'b00;  // rs + rt
  localparam logic [1:0] aluSub  = 2'b01;  // rt - rs
  localparam logic [1:0] aluXor  = 2'b10;
  localparam logic [1:0] aluAndn = 2'b11;  // rs & ~rt

  // one instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [4:0]             op;
      logic [regIdxWidth-1:0] rs;
      logic [regIdxWidth-1:0] rt;
      logic [regIdxWidth-1:0] rd;
      logic [1:0]             func;
    } rFmt;
    struct packed {
      logic [4:0]             op;
      logic [regIdxWidth-1:0] rs;
      logic [regIdxWidth-1:0] rd;
      logic [4:0]             imm5;
    } iFmt;
    struct packed {
      logic [4:0]             op;
      logic [regIdxWidth-1:0] rs;
      logic [7:0]             imm8;
    } bFmt;
  } instrWord;

endpackage

/* common/idExIf.sv */
/*
  decode to execute pipeline register bundle
  source side written by decode, sink side read by execute
*/
`timescale 1ns/10ps

interface idExIf;

  logic                                valid;
  logic [procPkg::dataWidth-1:0]       pc;      // address of next instruction
  logic [procPkg::dataWidth-1:0]       opA;
  logic [procPkg::dataWidth-1:0]       opB;
  logic [procPkg::dataWidth-1:0]       imm;     // already extended
  logic [procPkg::regIdxWidth-1:0]     rs;
  logic [procPkg::regIdxWidth-1:0]     rt;
  logic [procPkg::regIdxWidth-1:0]     rd;
  logic [1:0]                          aluFunc;
  logic                                useImm;
  logic                                regWrite;
  logic                                readsRs;
  logic                                readsRt;
  logic                                branch;
  logic                                branchOnZero;
  logic                                halt;
  logic                                illegal;

  modport source (output valid, pc, opA, opB, imm, rs, rt, rd, aluFunc, useImm,
                  regWrite, readsRs, readsRt, branch, branchOnZero, halt, illegal);

  modport sink (input valid, pc, opA, opB, imm, rs, rt, rd, aluFunc, useImm,
                regWrite, readsRs, readsRt, branch, branchOnZero, halt, illegal);

endinterface

/* fetch/fetchStage.sv */
/*
  fetch stage
  PC counter with redirect and freeze
  fetch/decode pipeline register
*/
`timescale 1ns/10ps

module fetchStage (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          redirect,
  input  logic [procPkg::dataWidth-1:0] redirectPc,
  input  logic                          stopFetch,
  output logic [procPkg::dataWidth-1:0] instrAddr,
  input  procPkg::instrWord             instrIn,
  output procPkg::instrWord             ifInstr,
  output logic [procPkg::dataWidth-1:0] ifPc,
  output logic                          ifValid
);

  logic [procPkg::dataWidth-1:0] pc;
  logic [procPkg::dataWidth-1:0] nextPc;
  logic                          frozen;  // sticky once halt or illegal seen
  logic                          hold;

  assign instrAddr = pc;
  assign nextPc    = pc + procPkg::pcStep;
  assign hold      = stopFetch | frozen;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc     <= '0;
      frozen <= 1'b0;
    end else begin
      frozen <= hold;
      if (redirect)
        pc <= redirectPc;  // taken branch wins
      else if (!hold)
        pc <= nextPc;
    end
  end

  // fetch/decode register
  always_ff @(posedge clk) begin
    if (!rstN)
      ifValid <= 1'b0;
    else
      ifValid <= ~(redirect | hold);  // flushed or frozen slots go invalid
  end

  always_ff @(posedge clk) begin
    ifInstr <= instrIn;
    ifPc    <= nextPc;
  end

endmodule

/* decode/regFile.sv */
/*
  eight-entry register file
  two combinational read ports, one write port
  same-cycle write data passed to the reads
*/
`timescale 1ns/10ps

module regFile (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [procPkg::regIdxWidth-1:0] rdIdxA,
  input  logic [procPkg::regIdxWidth-1:0] rdIdxB,
  output logic [procPkg::dataWidth-1:0]   rdDataA,
  output logic [procPkg::dataWidth-1:0]   rdDataB,
  input  logic                            wrEn,
  input  logic [procPkg::regIdxWidth-1:0] wrIdx,
  input  logic [procPkg::dataWidth-1:0]   wrData
);

  logic [procPkg::dataWidth-1:0] regs [procPkg::regCount];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < procPkg::regCount; i++)
        regs[i] <= '0;
    end else if (wrEn) begin
      regs[wrIdx] <= wrData;
    end
  end

  // write-through so decode sees the writeback of this cycle
  assign rdDataA = (wrEn && wrIdx == rdIdxA) ? wrData : regs[rdIdxA];
  assign rdDataB = (wrEn && wrIdx == rdIdxB) ? wrData : regs[rdIdxB];

endmodule

/* decode/decodeStage.sv */
/*
  decode stage
  opcode decode through the instruction views, immediate extension
  register read, halt and illegal detection
  decode/execute pipeline register
*/
`timescale 1ns/10ps

module decodeStage (
  input  logic                             clk,
  input  logic                             rstN,
  input  procPkg::instrWord                ifInstr,
  input  logic [procPkg::dataWidth-1:0]    ifPc,
  input  logic                             ifValid,
  input  logic                             redirect,
  input  logic                             wbEn,
  input  logic [procPkg::regIdxWidth-1:0]  wbReg,
  input  logic [procPkg::dataWidth-1:0]    wbData,
  output logic                             stopFetch,
  idExIf.source                            toEx
);

  localparam int immPad5 = procPkg::dataWidth - 5;
  localparam int immPad8 = procPkg::dataWidth - 8;

  logic [procPkg::dataWidth-1:0]   rsData;
  logic [procPkg::dataWidth-1:0]   rtData;
  logic [procPkg::dataWidth-1:0]   decImm;
  logic [procPkg::regIdxWidth-1:0] decRd;
  logic [1:0]                      decFunc;
  logic decUseImm;
  logic decRegWrite;
  logic decReadsRs;
  logic decReadsRt;
  logic decBranch;
  logic decOnZero;
  logic decHalt;
  logic decIllegal;

  regFile regs (
    .clk    (clk),
    .rstN   (rstN),
    .rdIdxA (ifInstr.rFmt.rs),
    .rdIdxB (ifInstr.rFmt.rt),
    .rdDataA(rsData),
    .rdDataB(rtData),
    .wrEn   (wbEn),
    .wrIdx  (wbReg),
    .wrData (wbData)
  );

  always_comb begin
    decFunc     = procPkg::aluAdd;
    decImm      = '0;
    decRd       = ifInstr.rFmt.rd;
    decUseImm   = 1'b0;
    decRegWrite = 1'b0;
    decReadsRs  = 1'b0;
    decReadsRt  = 1'b0;
    decBranch   = 1'b0;
    decOnZero   = 1'b0;
    decHalt     = 1'b0;
    decIllegal  = 1'b0;
    case (ifInstr.rFmt.op)
      procPkg::opHalt: decHalt = 1'b1;
      procPkg::opNop: begin
      end
      procPkg::opAddi: begin
        decImm      = {{immPad5{ifInstr.iFmt.imm5[4]}}, ifInstr.iFmt.imm5};
        decRd       = ifInstr.iFmt.rd;
        decUseImm   = 1'b1;
        decRegWrite = 1'b1;
        decReadsRs  = 1'b1;
      end
      procPkg::opXori: begin
        decFunc     = procPkg::aluXor;
        decImm      = {{immPad5{1'b0}}, ifInstr.iFmt.imm5};  // zero extended
        decRd       = ifInstr.iFmt.rd;
        decUseImm   = 1'b1;
        decRegWrite = 1'b1;
        decReadsRs  = 1'b1;
      end
      procPkg::opBeqz, procPkg::opBnez: begin
        decImm     = {{immPad8{ifInstr.bFmt.imm8[7]}}, ifInstr.bFmt.imm8};
        decReadsRs = 1'b1;
        decBranch  = 1'b1;
        decOnZero  = (ifInstr.rFmt.op == procPkg::opBeqz);
      end
      procPkg::opLbi: begin
        // rs field is the destination, A side reads as zero
        decImm      = {{immPad8{ifInstr.bFmt.imm8[7]}}, ifInstr.bFmt.imm8};
        decRd       = ifInstr.bFmt.rs;
        decUseImm   = 1'b1;
        decRegWrite = 1'b1;
      end
      procPkg::opAlu: begin
        decFunc     = ifInstr.rFmt.func;
        decRegWrite = 1'b1;
        decReadsRs  = 1'b1;
        decReadsRt  = 1'b1;
      end
      default: decIllegal = 1'b1;
    endcase
  end

  assign stopFetch = ifValid & (decHalt | decIllegal) & ~redirect;

  always_ff @(posedge clk) begin
    if (!rstN)
      toEx.valid <= 1'b0;
    else
      toEx.valid <= ifValid & ~redirect;  // squash on taken branch
  end

  always_ff @(posedge clk) begin
    toEx.pc           <= ifPc;
    toEx.opA          <= rsData;
    toEx.opB          <= rtData;
    toEx.imm          <= decImm;
    toEx.rs           <= ifInstr.rFmt.rs;
    toEx.rt           <= ifInstr.rFmt.rt;
    toEx.rd           <= decRd;
    toEx.aluFunc      <= decFunc;
    toEx.useImm       <= decUseImm;
    toEx.regWrite     <= decRegWrite;
    toEx.readsRs      <= decReadsRs;
    toEx.readsRt      <= decReadsRt;
    toEx.branch       <= decBranch;
    toEx.branchOnZero <= decOnZero;
    toEx.halt         <= decHalt;
    toEx.illegal      <= decIllegal;
  end

endmodule

/* execute/executeStage.sv */
/*
  execute stage
  operand forwarding from the writeback register, ALU
  branch resolution and redirect
  execute/writeback register, sticky halted and err
*/
`timescale 1ns/10ps

module executeStage (
  input  logic                             clk,
  input  logic                             rstN,
  idExIf.sink                              fromId,
  output logic                             redirect,
  output logic [procPkg::dataWidth-1:0]    redirectPc,
  output logic                             wbEn,
  output logic [procPkg::regIdxWidth-1:0]  wbReg,
  output logic [procPkg::dataWidth-1:0]    wbData,
  output logic                             halted,
  output logic                             err
);

  logic                          fwdHitA;
  logic                          fwdHitB;
  logic [procPkg::dataWidth-1:0] srcA;
  logic [procPkg::dataWidth-1:0] rtVal;
  logic [procPkg::dataWidth-1:0] srcB;
  logic [procPkg::dataWidth-1:0] aluOut;
  logic                          rsZero;
  logic                          stopping;

  // result one stage ahead writes a register we read
  assign fwdHitA = fromId.readsRs && wbEn && (wbReg == fromId.rs);
  assign fwdHitB = fromId.readsRt && wbEn && (wbReg == fromId.rt);

  always_comb begin
    if (!fromId.readsRs)
      srcA = '0;  // lbi passes imm through the adder
    else if (fwdHitA)
      srcA = wbData;
    else
      srcA = fromId.opA;
  end

  assign rtVal = fwdHitB ? wbData : fromId.opB;
  assign srcB  = fromId.useImm ? fromId.imm : rtVal;

  always_comb begin
    case (fromId.aluFunc)
      procPkg::aluAdd:  aluOut = srcA + srcB;
      procPkg::aluSub:  aluOut = srcB - srcA;  // rt minus rs
      procPkg::aluXor:  aluOut = srcA ^ srcB;
      procPkg::aluAndn: aluOut = srcA & ~srcB;
      default:          aluOut = srcA + srcB;
    endcase
  end

  // branch on the forwarded rs
  assign rsZero     = (srcA == '0);
  assign redirect   = fromId.valid & fromId.branch & (fromId.branchOnZero == rsZero);
  assign redirectPc = fromId.pc + fromId.imm;

  assign stopping = fromId.valid & (fromId.halt | fromId.illegal);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbEn   <= 1'b0;
      halted <= 1'b0;
      err    <= 1'b0;
    end else begin
      wbEn   <= fromId.valid & fromId.regWrite;
      halted <= halted | stopping;                        // stays up
      err    <= err | (fromId.valid & fromId.illegal);
    end
  end

  // writeback payload
  always_ff @(posedge clk) begin
    wbReg  <= fromId.rd;
    wbData <= aluOut;
  end

endmodule

/* logic/proc.sv */
/*
  core top level
  fetch, decode and execute stages joined by the
  decode/execute bundle, writeback bus out as plain ports
*/
`timescale 1ns/10ps

module proc (
  input  logic                            clk,
  input  logic                            rstN,
  output logic [procPkg::dataWidth-1:0]   instrAddr,
  input  logic [procPkg::dataWidth-1:0]   instrIn,
  output logic                            wbEn,
  output logic [procPkg::regIdxWidth-1:0] wbReg,
  output logic [procPkg::dataWidth-1:0]   wbData,
  output logic                            halted,
  output logic                            err
);

  procPkg::instrWord             ifInstr;
  logic [procPkg::dataWidth-1:0] ifPc;
  logic                          ifValid;
  logic                          redirect;
  logic [procPkg::dataWidth-1:0] redirectPc;
  logic                          stopFetch;

  idExIf idEx ();

  fetchStage fetch (
    .clk       (clk),
    .rstN      (rstN),
    .redirect  (redirect),
    .redirectPc(redirectPc),
    .stopFetch (stopFetch),
    .instrAddr (instrAddr),
    .instrIn   (instrIn),
    .ifInstr   (ifInstr),
    .ifPc      (ifPc),
    .ifValid   (ifValid)
  );

  decodeStage decode (
    .clk      (clk),
    .rstN     (rstN),
    .ifInstr  (ifInstr),
    .ifPc     (ifPc),
    .ifValid  (ifValid),
    .redirect (redirect),
    .wbEn     (wbEn),
    .wbReg    (wbReg),
    .wbData   (wbData),
    .stopFetch(stopFetch),
    .toEx     (idEx.source)
  );

  executeStage execute (
    .clk       (clk),
    .rstN      (rstN),
    .fromId    (idEx.sink),
    .redirect  (redirect),
    .redirectPc(redirectPc),
    .wbEn      (wbEn),
    .wbReg     (wbReg),
    .wbData    (wbData),
    .halted    (halted),
    .err       (err)
  );

endmodule

/* test/procModel.svh */
/*
  random program generator for the core testbench
  sequential reference model giving the expected writes and err
  works on progMem, progLen and the expected-write queues of procTb
*/

// fills progMem with len words, the last one halt or an unknown opcode
task automatic genProgram(input int len, input bit withBranch, input bit endIllegal);
  int unsigned pick;
  int          room;
  int          k;
  logic [2:0]  base;
  logic [2:0]  rs;
  logic [2:0]  rt;
  logic [2:0]  rd;
  logic [4:0]  badOp;
  base    = 3'($urandom);
  progLen = len;
  for (int i = 0; i < len - 1; i++) begin
    pick = withBranch ? $urandom % 100 : $urandom % 80;
    rs   = base + 3'($urandom % 4);  // four-register pool per program
    rt   = base + 3'($urandom % 4);
    rd   = base + 3'($urandom % 4);
    room = len - 2 - i;              // slots up to the terminator
    if (pick >= 80 && room > 0) begin
      k = 1 + int'($urandom % 6);
      if (k > room)
        k = room;                    // never jump past the terminator
      progMem[i] = {($urandom % 2 == 0) ? procPkg::opBeqz : procPkg::opBnez, rs, 8'(2 * k)};
    end else if (pick >= 60 && pick < 80) begin
      progMem[i] = {procPkg::opLbi, rd, 8'($urandom)};
    end else if (pick >= 45 && pick < 60) begin
      progMem[i] = {procPkg::opXori, rs, rd, 5'($urandom)};
    end else if (pick >= 30 && pick < 45) begin
      progMem[i] = {procPkg::opAddi, rs, rd, 5'($urandom)};
    end else begin
      progMem[i] = {procPkg::opAlu, rs, rt, rd, 2'($urandom)};
    end
  end
  if (endIllegal) begin
    badOp = procPkg::opHalt;
    while (badOp inside {procPkg::opHalt, procPkg::opNop, procPkg::opAddi, procPkg::opXori,
                         procPkg::opBeqz, procPkg::opBnez, procPkg::opLbi, procPkg::opAlu})
      badOp = 5'($urandom);
    progMem[len - 1] = {badOp, 11'($urandom)};
  end else begin
    progMem[len - 1] = {procPkg::opHalt, 11'h000};
  end
endtask

// in-order execution from zeroed registers
task automatic runModel();
  logic [15:0] r [8];
  logic [15:0] pc;
  logic [15:0] w;
  logic [15:0] val;
  logic [2:0]  dst;
  bit          writes;
  bit          done;
  int          steps;
  expReg.delete();
  expData.delete();
  expErr = 1'b0;
  for (int i = 0; i < 8; i++)
    r[i] = '0;
  pc    = '0;
  done  = 1'b0;
  steps = 0;
  while (!done && steps < 200) begin
    w      = wordAt(int'(pc >> 1));
    writes = 1'b0;
    val    = '0;
    dst    = '0;
    pc     = pc + 16'd2;  // branch base is the next address
    case (w[15:11])
      procPkg::opHalt: done = 1'b1;
      procPkg::opNop: begin
      end
      procPkg::opAddi: begin
        dst    = w[7:5];
        val    = r[w[10:8]] + {{11{w[4]}}, w[4:0]};
        writes = 1'b1;
      end
      procPkg::opXori: begin
        dst    = w[7:5];
        val    = r[w[10:8]] ^ {11'h000, w[4:0]};  // zero extended
        writes = 1'b1;
      end
      procPkg::opBeqz: begin
        if (r[w[10:8]] == 16'h0000)
          pc = pc + {{8{w[7]}}, w[7:0]};
      end
      procPkg::opBnez: begin
        if (r[w[10:8]] != 16'h0000)
          pc = pc + {{8{w[7]}}, w[7:0]};
      end
      procPkg::opLbi: begin
        dst    = w[10:8];
        val    = {{8{w[7]}}, w[7:0]};
        writes = 1'b1;
      end
      procPkg::opAlu: begin
        dst    = w[4:2];
        writes = 1'b1;
        case (w[1:0])
          2'b00:   val = r[w[10:8]] + r[w[7:5]];
          2'b01:   val = r[w[7:5]] - r[w[10:8]];   // rt minus rs
          2'b10:   val = r[w[10:8]] ^ r[w[7:5]];
          default: val = r[w[10:8]] & ~r[w[7:5]];
        endcase
      end
      default: begin
        expErr = 1'b1;
        done   = 1'b1;
      end
    endcase
    if (writes) begin
      r[dst] = val;
      expReg.push_back(dst);
      expData.push_back(val);
    end
    steps++;
  end
endtask

/* test/procTb.sv */
/*
  testbench for the pipelined core
  clock, reset, instruction memory and writeback checker
  random programs compared with the model in procModel.svh
*/
`timescale 1ns/10ps

module procTb;

  logic        clk = 1'b0;
  logic        rstN = 1'b0;
  logic [15:0] instrAddr;
  logic [15:0] instrIn = 16'h0800;  // nop
  logic        wbEn;
  logic [2:0]  wbReg;
  logic [15:0] wbData;
  logic        halted;
  logic        err;

  logic [15:0] progMem [64];  // program under test
  int          progLen;
  int          progLens [10];
  logic [2:0]  expReg [$];
  logic [15:0] expData [$];
  bit          expErr;
  logic [2:0]  popReg;
  logic [15:0] popData;
  int          testErrors;
  int          gotWrites;
  int          cycleCount;
  int          cycleLimit;
  int          passCount;
  int          failCount;

  proc DUT (
    .clk      (clk),
    .rstN     (rstN),
    .instrAddr(instrAddr),
    .instrIn  (instrIn),
    .wbEn     (wbEn),
    .wbReg    (wbReg),
    .wbData   (wbData),
    .halted   (halted),
    .err      (err)
  );

  always #2 clk = ~clk;

  function automatic logic [15:0] wordAt(input int idx);
    logic [15:0] w;
    if (idx >= 0 && idx < progLen)
      w = progMem[idx];
    else
      w = {procPkg::opNop, 11'h000};  // past the end reads as nop
    return w;
  endfunction

  `include "procModel.svh"

  // instruction memory answers the current fetch address
  always @(negedge clk)
    instrIn <= wordAt(int'(instrAddr >> 1));

  // writeback bus against the model, in order
  always @(negedge clk) begin
    if (rstN && wbEn) begin
      gotWrites++;
      assert (halted == 1'b0) else begin
        $display("FAILED halted expected 0 got %h at a write to r%0d", halted, wbReg);
        testErrors++;
      end
      assert (expReg.size() > 0) else begin
        $display("unexpected write to r%0d after the last write of the model", wbReg);
        testErrors++;
      end
      if (expReg.size() > 0) begin
        popReg  = expReg.pop_front();
        popData = expData.pop_front();
        assert (wbReg == popReg) else begin
          $display("FAILED wbReg expected %h got %h", popReg, wbReg);
          testErrors++;
        end
        assert (wbData == popData) else begin
          $display("FAILED wbData expected %h got %h", popData, wbData);
          testErrors++;
        end
      end
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    @(posedge clk);  // limit is set by then
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout, the core did not finish within %0d cycles", cycleLimit);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic runProgram(input int num, input bit withBranch, input bit endIllegal,
                            input string kind);
    int expCount;
    genProgram(progLens[num], withBranch, endIllegal);
    runModel();
    expCount   = expReg.size();
    gotWrites  = 0;
    testErrors = 0;
    @(negedge clk);
    rstN = 1'b0;
    repeat (3) @(negedge clk);
    assert (wbEn == 1'b0) else begin
      $display("FAILED wbEn expected 0 got %h", wbEn);
      testErrors++;
    end
    assert (halted == 1'b0) else begin
      $display("FAILED halted expected 0 got %h", halted);
      testErrors++;
    end
    assert (err == 1'b0) else begin
      $display("FAILED err expected 0 got %h", err);
      testErrors++;
    end
    assert (instrAddr == 16'h0000) else begin
      $display("FAILED instrAddr expected 0000 got %h", instrAddr);
      testErrors++;
    end
    rstN = 1'b1;
    while (halted !== 1'b1)
      @(negedge clk);
    repeat (4) @(negedge clk);  // stray writes after halt land here
    assert (halted == 1'b1) else begin
      $display("FAILED halted expected 1 got %h", halted);
      testErrors++;
    end
    assert (err == expErr) else begin
      $display("FAILED err expected %h got %h", expErr, err);
      testErrors++;
    end
    assert (gotWrites == expCount) else begin
      $display("write count wrong, the model made %0d writes and the core %0d",
               expCount, gotWrites);
      testErrors++;
    end
    if (testErrors == 0) begin
      passCount++;
      $display("test %0d %s: passed, %0d instructions, %0d writes", num, kind,
               progLen, gotWrites);
    end else begin
      failCount++;
      $display("test %0d %s: failed with %0d errors", num, kind, testErrors);
    end
  endtask

  initial begin
    void'($urandom(32'h298c766b));
    passCount  = 0;
    failCount  = 0;
    cycleLimit = 0;
    for (int p = 0; p < 10; p++) begin
      progLens[p] = 20 + int'($urandom % 21);
      cycleLimit  = cycleLimit + progLens[p] * 3 + 20;
    end
    for (int p = 0; p < 10; p++) begin
      if (p < 4)
        runProgram(p, 1'b0, 1'b0, "straight");
      else if (p < 8)
        runProgram(p, 1'b1, 1'b0, "branch");
      else
        runProgram(p, 1'b1, 1'b1, "illegal");
    end
    $display("tests run 10, passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+test
common/procPkg.sv
common/idExIf.sv
fetch/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
logic/proc.sv
test/procTb.sv

/* Makefile */
# Verilator build and run of the pipelined core testbench

SRCS := $(wildcard common/*.sv fetch/*.sv decode/*.sv execute/*.sv logic/*.sv \
          test/*.sv test/*.svh)

.PHONY: all run clean

all: run

obj_dir/VprocTb: verilog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  -f verilog.f --top-module procTb -o VprocTb

run: obj_dir/VprocTb
	@out="$$(./obj_dir/VprocTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
